// File: flist.f
+incdir+.
rot_pkg.sv
stream_delay.sv
raster_tracker.sv
rotate_mapper.sv
bank_switch.sv
image_rotator.sv
sram_model.sv
tb_image_rotator.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the image rotator testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary -j 0 -Wno-fatal \
   --top-module tb_image_rotator \
   -f flist.f \
   -o sim_rot

./obj_dir/sim_rot | tee sim.log

if grep -q "Test FAILED" sim.log; then
   echo "simulation failed"
   exit 1
fi

echo "simulation passed"

// File: tb_image_rotator.sv
/* image rotator testbench */
`timescale 1ns/1ps
`include "rot_settings.svh"

module tb_image_rotator
   import rot_pkg::*;
();

   localparam int AW     = `ROT_ADDR_WIDTH;
   localparam int DW     = `ROT_DATA_WIDTH;
   localparam int ANW    = `ROT_ANGLE_WIDTH;
   localparam int FRAC   = `ROT_ANGLE_WIDTH - 2;
   localparam int DMASK  = (1 << `ROT_DIM_WIDTH) - 1;
   localparam int LAT    = `ROT_LATENCY;
   localparam int PERIOD = 4;
   localparam int NTESTS = 5;
   localparam sram_req_t IDLE_REQ = '{addr: '0, web: 1'b1, oeb: 1'b1, wdata: '0};

   logic                  clk;
   logic                  resetb;
   logic                  enable;
   stream_t               in_tok;
   logic signed [ANW-1:0] sin_theta;
   logic signed [ANW-1:0] cos_theta;
   stream_t               out_tok;
   sram_req_t             sram0;
   sram_req_t             sram1;
   logic [DW-1:0]         rdata0;
   logic [DW-1:0]         rdata1;

   // reference images of both banks
   logic [DW-1:0] img [0:1][0:(1 << AW)-1];

   // reference tracker state
   int        m_row;
   int        m_col;
   int        m_cols;
   int        m_rows;
   int        m_sin;
   int        m_cos;
   int        m_wr;
   logic      m_bank;

   // stimulus settings of the running test
   logic      cur_en;
   int        cur_sin;
   int        cur_cos;

   // expected outputs with one entry per driven cycle
   stream_t   exp_tok_q [$];
   sram_req_t exp_s0_q [$];
   sram_req_t exp_s1_q [$];
   int        err_cnt;
   int        n_checks;

   image_rotator u_dut (
      .clk       (clk),
      .resetb    (resetb),
      .enable    (enable),
      .in_tok    (in_tok),
      .sin_theta (sin_theta),
      .cos_theta (cos_theta),
      .out_tok   (out_tok),
      .sram0     (sram0),
      .sram1     (sram1),
      .rdata0    (rdata0),
      .rdata1    (rdata1)
   );

   sram_model #(.BANK(1'b0)) u_sram0 (.clk(clk), .req(sram0), .rdata(rdata0));
   sram_model #(.BANK(1'b1)) u_sram1 (.clk(clk), .req(sram1), .rdata(rdata1));

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

   // worst case cycles of one frame with two idle cycles before every token
   function automatic int frame_cycles(input int cols, input int rows);
      return 3 * (2 + rows * (cols + 2));
   endfunction

   function automatic int worst_cycles();
      int n;
      n = 3 + NTESTS * (LAT + 1);
      n += 9 * frame_cycles(16, 12);
      n += 3 * frame_cycles(10, 8);
      return n;
   endfunction

   // same preload pattern as the sram banks
   function automatic logic [DW-1:0] fill_word(input logic b, input logic [AW-1:0] a);
      return (a[15:0] ^ {a[20:16], a[20:10]}) ^ (b ? 16'h5a5a : 16'h0000);
   endfunction

   function automatic stream_t idle_token();
      stream_t t;
      t.valid = 1'b0;
      t.dtype = dtype_t'(3'($urandom_range(0, 5)));
      t.data  = DW'($urandom);
      return t;
   endfunction

   // rotate the current source position about the frame centre
   task automatic map_position(output logic [AW-1:0] addr, output logic oob);
      int cx;
      int cy;
      int dc;
      int dr;
      int rc;
      int rr;
      int cb;
      int rb;
      cx = m_cols / 2;
      cy = m_rows / 2;
      dc = m_col - cx;
      dr = m_row - cy;
      rc = ((dc * m_cos - dr * m_sin) >>> FRAC) + cx;
      rr = ((dc * m_sin + dr * m_cos) >>> FRAC) + cy;
      // bayer phase comes from the source position
      cb = (rc & ~1) | (m_col & 1);
      rb = (rr & ~1) | (m_row & 1);
      oob = (cb < 0) || (cb >= m_cols) || (rb < 0) || (rb >= m_rows);
      addr = AW'((rb & DMASK) * m_cols + (cb & DMASK));
   endtask

   // predict outputs for one accepted token and advance the reference
   task automatic model_token(input stream_t t, input logic en);
      stream_t       exp;
      sram_req_t     wr;
      sram_req_t     rd;
      logic [AW-1:0] ra;
      logic          oob;
      exp = t;
      wr  = IDLE_REQ;
      rd  = IDLE_REQ;
      if (t.valid && en && t.dtype == PIXEL) begin
         map_position(ra, oob);
         wr = '{addr: AW'(m_wr), web: 1'b0, oeb: 1'b1, wdata: t.data};
         rd = '{addr: ra, web: 1'b1, oeb: 1'b0, wdata: '0};
         exp.data = oob ? '0 : img[!m_bank][ra];
         img[m_bank][AW'(m_wr)] = t.data;
         m_wr++;
      end
      // write counter restarts even while disabled
      if (t.valid && t.dtype == FRAME_START) begin
         m_wr = 0;
      end
      if (t.valid && en) begin
         case (t.dtype)
            FRAME_START: begin
               m_row  = 0;
               m_col  = 0;
               m_bank = !m_bank;
               m_sin  = cur_sin;
               m_cos  = cur_cos;
            end
            ROW_START: m_col = 0;
            PIXEL:     m_col++;
            ROW_END: begin
               m_row++;
               m_cols = m_col;
            end
            FRAME_END: m_rows = m_row;
            default: begin
            end
         endcase
      end
      // only pixels carry requests and a pixel never moves the bank
      exp_tok_q.push_back(exp);
      exp_s0_q.push_back(m_bank ? rd : wr);
      exp_s1_q.push_back(m_bank ? wr : rd);
   endtask

   task automatic drive_token(input stream_t t);
      @(posedge clk);
      in_tok    <= t;
      enable    <= cur_en;
      sin_theta <= ANW'(cur_sin);
      cos_theta <= ANW'(cur_cos);
      model_token(t, cur_en);
   endtask

   // one token after a short random idle gap
   task automatic send_token(input dtype_t kind, input logic [DW-1:0] d);
      int gap;
      gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 2) : 0;
      repeat (gap) begin
         drive_token(idle_token());
      end
      drive_token('{valid: 1'b1, dtype: kind, data: d});
   endtask

   task automatic send_frame(input int cols, input int rows);
      send_token(FRAME_START, DW'($urandom));
      for (int r = 0; r < rows; r++) begin
         send_token(ROW_START, DW'($urandom));
         for (int c = 0; c < cols; c++) begin
            send_token(PIXEL, DW'($urandom));
         end
         send_token(ROW_END, DW'($urandom));
      end
      send_token(FRAME_END, DW'($urandom));
   endtask

   task automatic check_stream(input string name, input stream_t exp, input stream_t got);
      n_checks++;
      if (exp.valid !== got.valid ||
          (exp.valid && (exp.dtype !== got.dtype || exp.data !== got.data))) begin
         err_cnt++;
         $display("Error: time %0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic check_sram(input string name, input sram_req_t exp, input sram_req_t got);
      n_checks++;
      if (exp !== got) begin
         err_cnt++;
         $display("Error: time %0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      if (exp_tok_q.size() > LAT) begin
         check_stream("out_tok", exp_tok_q.pop_front(), out_tok);
      end
      if (exp_s0_q.size() > LAT - 2) begin
         check_sram("sram0", exp_s0_q.pop_front(), sram0);
         check_sram("sram1", exp_s1_q.pop_front(), sram1);
      end
   end

   task automatic run_test(input string name, input logic en, input int frames,
                           input int cols, input int rows, input bit rand_angle);
      int start;
      start  = err_cnt;
      cur_en = en;
      for (int f = 0; f < frames; f++) begin
         if (rand_angle) begin
            cur_cos = int'($urandom_range(0, 512)) - 256;
            cur_sin = int'($urandom_range(0, 512)) - 256;
         end else begin
            cur_cos = 256;
            cur_sin = 0;
         end
         send_frame(cols, rows);
      end
      // let the pipeline drain before the test is scored
      repeat (LAT + 1) begin
         drive_token(idle_token());
      end
      $display("test %s finished with %0d errors", name, err_cnt - start);
   endtask

   initial begin
      #(2 * worst_cycles() * PERIOD);
      $display("timeout, the stimulus did not finish in the expected time");
      $display("Test FAILED");
      $finish;
   end

   initial begin
      void'($urandom(25726));
      resetb    = 1'b0;
      enable    = 1'b0;
      in_tok    = '0;
      sin_theta = '0;
      cos_theta = '0;
      cur_en    = 1'b0;
      cur_sin   = 0;
      cur_cos   = 256;
      err_cnt   = 0;
      n_checks  = 0;
      m_row     = 0;
      m_col     = 0;
      m_cols    = `ROT_RESET_COLS;
      m_rows    = `ROT_RESET_ROWS;
      m_sin     = 0;
      m_cos     = 0;
      m_wr      = 0;
      m_bank    = 1'b0;
      for (int a = 0; a < (1 << AW); a++) begin
         img[0][a] = fill_word(1'b0, AW'(a));
         img[1][a] = fill_word(1'b1, AW'(a));
      end
      repeat (3) @(posedge clk);
      resetb <= 1'b1;

      run_test("bypass", 1'b0, 2, 16, 12, 1'b0);
      run_test("identity", 1'b1, 3, 16, 12, 1'b0);
      run_test("rotate", 1'b1, 3, 16, 12, 1'b1);
      run_test("resize", 1'b1, 3, 10, 8, 1'b1);
      run_test("regrow", 1'b1, 1, 16, 12, 1'b1);

      $display("%0d tests, %0d checks, %0d errors", NTESTS, n_checks, err_cnt);
      if (err_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: sram_model.sv
/* testbench sram bank */
`timescale 1ns/1ps
`include "rot_settings.svh"

module sram_model
   import rot_pkg::*;
#(
   parameter logic BANK = 1'b0
) (
   input  logic                       clk,
   input  sram_req_t                  req,
   output logic [`ROT_DATA_WIDTH-1:0] rdata
);

   localparam int DEPTH = 1 << `ROT_ADDR_WIDTH;

   logic [`ROT_DATA_WIDTH-1:0] mem [0:DEPTH-1];

   // preload so that reads of unwritten words are predictable
   initial begin
      logic [`ROT_ADDR_WIDTH-1:0] a;
      for (int i = 0; i < DEPTH; i++) begin
         a = `ROT_ADDR_WIDTH'(i);
         // every address bit reaches the data, bank bit flips the pattern
         mem[i] = (a[15:0] ^ {a[20:16], a[20:10]}) ^ (BANK ? 16'h5a5a : 16'h0000);
      end
   end

   // synchronous write on active low write enable
   always @(posedge clk) begin
      if (!req.web) begin
         mem[req.addr] <= req.wdata;
      end
   end

   // combinational read
   assign rdata = mem[req.addr];

endmodule

// File: image_rotator.sv
/* image rotator top */
`timescale 1ns/1ps
`include "rot_settings.svh"

module image_rotator
   import rot_pkg::*;
(
   input  logic                               clk,
   input  logic                               resetb,
   input  logic                               enable,
   input  stream_t                            in_tok,
   input  logic signed [`ROT_ANGLE_WIDTH-1:0] sin_theta,
   input  logic signed [`ROT_ANGLE_WIDTH-1:0] cos_theta,
   output stream_t                            out_tok,
   output sram_req_t                          sram0,
   output sram_req_t                          sram1,
   input  logic [`ROT_DATA_WIDTH-1:0]         rdata0,
   input  logic [`ROT_DATA_WIDTH-1:0]         rdata1
);

   pos_t                               pos;
   logic signed [`ROT_ANGLE_WIDTH-1:0] sin_lat;
   logic signed [`ROT_ANGLE_WIDTH-1:0] cos_lat;
   logic                               bank;
   logic [`ROT_ADDR_WIDTH-1:0]         raddr;
   logic                               out_of_bounds;
   logic                               pix_valid;
   logic [`ROT_DATA_WIDTH-1:0]         pix_data;
   stream_t                            tok_d;

   raster_tracker u_tracker (
      .clk       (clk),
      .resetb    (resetb),
      .enable    (enable),
      .in_tok    (in_tok),
      .sin_theta (sin_theta),
      .cos_theta (cos_theta),
      .pos       (pos),
      .sin_lat   (sin_lat),
      .cos_lat   (cos_lat),
      .bank      (bank)
   );

   rotate_mapper u_mapper (
      .pos           (pos),
      .sin_lat       (sin_lat),
      .cos_lat       (cos_lat),
      .raddr         (raddr),
      .out_of_bounds (out_of_bounds)
   );

   // token path, same delay as the sram round trip
   stream_delay #(
      .T     (stream_t),
      .DEPTH (`ROT_LATENCY)
   ) u_bypass (
      .clk    (clk),
      .resetb (resetb),
      .din    (in_tok),
      .dout   (tok_d)
   );

   bank_switch u_banks (
      .clk           (clk),
      .resetb        (resetb),
      .enable        (enable),
      .in_tok        (in_tok),
      .bank          (bank),
      .raddr         (raddr),
      .out_of_bounds (out_of_bounds),
      .sram0         (sram0),
      .sram1         (sram1),
      .rdata0        (rdata0),
      .rdata1        (rdata1),
      .pix_valid     (pix_valid),
      .pix_data      (pix_data)
   );

   // rotated pixel replaces the delayed data, control tokens pass as is
   always_comb begin
      out_tok = tok_d;
      if (pix_valid) begin
         out_tok.data = pix_data;
      end
   end

endmodule

// File: bank_switch.sv
/* sram bank switch */
`timescale 1ns/1ps
`include "rot_settings.svh"

module bank_switch
   import rot_pkg::*;
(
   input  logic                       clk,
   input  logic                       resetb,
   input  logic                       enable,
   input  stream_t                    in_tok,
   input  logic                       bank,
   input  logic [`ROT_ADDR_WIDTH-1:0] raddr,
   input  logic                       out_of_bounds,
   output sram_req_t                  sram0,
   output sram_req_t                  sram1,
   input  logic [`ROT_DATA_WIDTH-1:0] rdata0,
   input  logic [`ROT_DATA_WIDTH-1:0] rdata1,
   output logic                       pix_valid,
   output logic [`ROT_DATA_WIDTH-1:0] pix_data
);

   localparam sram_req_t REQ_IDLE = '{addr: '0, web: 1'b1, oeb: 1'b1, wdata: '0};

   logic                       frame_start;
   logic                       pixel;
   logic [`ROT_ADDR_WIDTH-1:0] wr_cnt;
   logic                       rd_active;
   logic                       rd_bank;
   logic                       rd_valid_s;
   logic [`ROT_DATA_WIDTH-1:0] rdata_s;
   logic                       ob_d;

   assign frame_start = in_tok.valid && (in_tok.dtype == FRAME_START);
   assign pixel       = in_tok.valid && (in_tok.dtype == PIXEL);

   // edge 1, issue write to one bank and rotated read to the other
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         sram0     <= REQ_IDLE;
         sram1     <= REQ_IDLE;
         wr_cnt    <= '0;
         rd_active <= 1'b0;
         rd_bank   <= 1'b0;
      end else begin
         sram0     <= REQ_IDLE;
         sram1     <= REQ_IDLE;
         rd_active <= 1'b0;
         if (frame_start) begin
            // pixels land at their raster index
            wr_cnt <= '0;
         end else if (enable && pixel) begin
            wr_cnt    <= wr_cnt + 1'b1;
            rd_active <= 1'b1;
            rd_bank   <= ~bank;
            if (!bank) begin
               sram0 <= '{addr: wr_cnt, web: 1'b0, oeb: 1'b1, wdata: in_tok.data};
               sram1 <= '{addr: raddr, web: 1'b1, oeb: 1'b0, wdata: '0};
            end else begin
               sram1 <= '{addr: wr_cnt, web: 1'b0, oeb: 1'b1, wdata: in_tok.data};
               sram0 <= '{addr: raddr, web: 1'b1, oeb: 1'b0, wdata: '0};
            end
         end
      end
   end

   // read strobe follows the request by one and two edges
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         rd_valid_s <= 1'b0;
         pix_valid  <= 1'b0;
      end else begin
         rd_valid_s <= rd_active;
         pix_valid  <= rd_valid_s;
      end
   end

   // edge 2 samples the bank that was read, edge 3 sends the pixel
   always_ff @(posedge clk) begin
      rdata_s  <= rd_bank ? rdata1 : rdata0;
      pix_data <= ob_d ? '0 : rdata_s;
   end

   // flag lines up with the sampled read data
   stream_delay #(
      .T     (logic),
      .DEPTH (`ROT_LATENCY - 1)
   ) u_ob_delay (
      .clk    (clk),
      .resetb (resetb),
      .din    (out_of_bounds),
      .dout   (ob_d)
   );

endmodule

// File: rotate_mapper.sv
/* rotated address mapper */
`timescale 1ns/1ps
`include "rot_settings.svh"

module rotate_mapper
   import rot_pkg::*;
(
   input  pos_t                               pos,
   input  logic signed [`ROT_ANGLE_WIDTH-1:0] sin_lat,
   input  logic signed [`ROT_ANGLE_WIDTH-1:0] cos_lat,
   output logic [`ROT_ADDR_WIDTH-1:0]         raddr,
   output logic                               out_of_bounds
);

   localparam int DW   = `ROT_DIM_WIDTH;
   localparam int AW   = `ROT_ANGLE_WIDTH;
   localparam int CW   = DW + 1;
   localparam int SW   = CW + AW + 1;
   localparam int FRAC = AW - 2;

   logic signed [CW-1:0] col_c;
   logic signed [CW-1:0] row_c;
   logic signed [SW-1:0] col_m;
   logic signed [SW-1:0] row_m;
   logic signed [SW-1:0] col_o;
   logic signed [SW-1:0] row_o;
   logic signed [SW-1:0] col_b;
   logic signed [SW-1:0] row_b;
   logic signed [SW-1:0] cols_ext;
   logic signed [SW-1:0] rows_ext;
   logic [2*DW-1:0]      lin;

   // frame size widened so it compares against the signed position
   assign cols_ext = $signed({{(SW-DW){1'b0}}, pos.num_cols});
   assign rows_ext = $signed({{(SW-DW){1'b0}}, pos.num_rows});

   // move origin to the image centre
   assign col_c = $signed({1'b0, pos.col}) - $signed({2'b0, pos.num_cols[DW-1:1]});
   assign row_c = $signed({1'b0, pos.row}) - $signed({2'b0, pos.num_rows[DW-1:1]});

   // rotation matrix
   assign col_m = col_c * cos_lat - row_c * sin_lat;
   assign row_m = col_c * sin_lat + row_c * cos_lat;

   // drop fraction bits, then back to the top left origin
   assign col_o = (col_m >>> FRAC) + (cols_ext >>> 1);
   assign row_o = (row_m >>> FRAC) + (rows_ext >>> 1);

   // keep the bayer phase of the source pixel
   assign col_b = {col_o[SW-1:1], pos.col[0]};
   assign row_b = {row_o[SW-1:1], pos.row[0]};

   assign out_of_bounds = (col_b < 0) || (col_b >= cols_ext) ||
                          (row_b < 0) || (row_b >= rows_ext);

   // raster index inside the stored frame
   assign lin   = row_b[DW-1:0] * pos.num_cols + {{DW{1'b0}}, col_b[DW-1:0]};
   assign raddr = lin[`ROT_ADDR_WIDTH-1:0];

endmodule

// File: raster_tracker.sv
/* raster position tracker */
`timescale 1ns/1ps
`include "rot_settings.svh"

module raster_tracker
   import rot_pkg::*;
(
   input  logic                               clk,
   input  logic                               resetb,
   input  logic                               enable,
   input  stream_t                            in_tok,
   input  logic signed [`ROT_ANGLE_WIDTH-1:0] sin_theta,
   input  logic signed [`ROT_ANGLE_WIDTH-1:0] cos_theta,
   output pos_t                               pos,
   output logic signed [`ROT_ANGLE_WIDTH-1:0] sin_lat,
   output logic signed [`ROT_ANGLE_WIDTH-1:0] cos_lat,
   output logic                               bank
);

   localparam int DW = `ROT_DIM_WIDTH;

   // position of the next pixel in the current frame
   logic [DW-1:0] row_cnt;
   logic [DW-1:0] col_cnt;

   // frame size as measured from the last row end and frame end
   logic [DW-1:0] num_cols;
   logic [DW-1:0] num_rows;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_cnt  <= '0;
         col_cnt  <= '0;
         num_cols <= DW'(`ROT_RESET_COLS);
         num_rows <= DW'(`ROT_RESET_ROWS);
         sin_lat  <= '0;
         cos_lat  <= '0;
         bank     <= 1'b0;
      end else if (enable && in_tok.valid) begin
         case (in_tok.dtype)
            FRAME_START: begin
               row_cnt <= '0;
               col_cnt <= '0;
               // swap read and write banks, angle held for the whole frame
               bank    <= ~bank;
               sin_lat <= sin_theta;
               cos_lat <= cos_theta;
            end
            ROW_START: begin
               col_cnt <= '0;
            end
            PIXEL: begin
               col_cnt <= col_cnt + 1'b1;
            end
            ROW_END: begin
               // column counter now holds the pixels seen in this row
               row_cnt  <= row_cnt + 1'b1;
               num_cols <= col_cnt;
            end
            FRAME_END: begin
               num_rows <= row_cnt;
            end
            default: begin
               // idle token, nothing to track
            end
         endcase
      end
   end

   assign pos = '{row: row_cnt, col: col_cnt, num_cols: num_cols, num_rows: num_rows};

endmodule

// File: stream_delay.sv
/* register delay line */
`timescale 1ns/1ps

module stream_delay #(
   parameter type T     = logic,
   parameter int  DEPTH = 3
) (
   input  logic clk,
   input  logic resetb,
   input  T     din,
   output T     dout
);

   // stage 0 takes the input, last stage drives the output
   T stage [DEPTH];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         for (int i = 0; i < DEPTH; i++) begin
            stage[i] <= '0;
         end
      end else begin
         stage[0] <= din;
         for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   assign dout = stage[DEPTH-1];

endmodule

// File: rot_pkg.sv
/* rotator types */
`include "rot_settings.svh"

package rot_pkg;

   // token kinds carried on the stream
   typedef enum logic [2:0] {
      NONE        = 3'd0,
      FRAME_START = 3'd1,
      ROW_START   = 3'd2,
      PIXEL       = 3'd3,
      ROW_END     = 3'd4,
      FRAME_END   = 3'd5
   } dtype_t;

   // one stream word, fields only meaningful while valid is high
   typedef struct packed {
      logic                       valid;
      dtype_t                     dtype;
      logic [`ROT_DATA_WIDTH-1:0] data;
   } stream_t;

   // source position plus measured frame size
   typedef struct packed {
      logic [`ROT_DIM_WIDTH-1:0] row;
      logic [`ROT_DIM_WIDTH-1:0] col;
      logic [`ROT_DIM_WIDTH-1:0] num_cols;
      logic [`ROT_DIM_WIDTH-1:0] num_rows;
   } pos_t;

   // request to one sram bank, enables active low
   typedef struct packed {
      logic [`ROT_ADDR_WIDTH-1:0] addr;
      logic                       web;
      logic                       oeb;
      logic [`ROT_DATA_WIDTH-1:0] wdata;
   } sram_req_t;

endpackage

// File: rot_settings.svh
/* rotator settings */
`ifndef ROT_SETTINGS_SVH
`define ROT_SETTINGS_SVH

// external sram address width
`define ROT_ADDR_WIDTH 21

// bayer pixel width
`define ROT_DATA_WIDTH 16

// signed sine and cosine, 1.0 is 2**(width-2)
`define ROT_ANGLE_WIDTH 10

// row and column counter width
`define ROT_DIM_WIDTH 11

// frame size assumed until the first measurement
`define ROT_RESET_COLS 1280
`define ROT_RESET_ROWS 720

// input to output delay in cycles
`define ROT_LATENCY 3

`endif
